// File: viterbi_dec.f
+incdir+sim
logic/viterbi_pkg.sv
logic/branch_metric.sv
logic/stage_reg.sv
logic/add_compare_select.sv
logic/survivor_exchange.sv
logic/viterbi_dec.sv
sim/tb_viterbi_dec.sv

// File: Makefile
TOP = tb_viterbi_dec

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): viterbi_dec.f logic/*.sv sim/*.sv sim/*.svh
	verilator --binary --timing -f viterbi_dec.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

lint:
	verilator --lint-only --timing -f viterbi_dec.f --top-module $(TOP)
	verilator --lint-only logic/viterbi_pkg.sv logic/branch_metric.sv \
		logic/stage_reg.sv logic/add_compare_select.sv \
		logic/survivor_exchange.sv logic/viterbi_dec.sv --top-module viterbi_dec

clean:
	rm -rf obj_dir

// File: sim/tb_viterbi_model.svh
// ----------------------------------------------------------
// Viterbi testbench model
// LFSR random source, reference (7,5) encoder and the
// expected decoded bit queue, included inside the tb top
// ----------------------------------------------------------

`ifndef TB_VITERBI_MODEL_SVH
`define TB_VITERBI_MODEL_SVH

// ----------------------------------------------------------
// Random source
// ----------------------------------------------------------
// 16-bit Fibonacci LFSR, taps 16, 14, 13, 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
   logic fb;
   fb = s[15] ^ s[13] ^ s[12] ^ s[10];
   return {s[14:0], fb};
endfunction

// One LFSR step per bit taken, newest bit lands in bit 0
task automatic take_bits(input int n, output int val);
   val = 0;
   for (int i = 0; i < n; i++)
   begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = (val << 1) | int'(lfsr_q[0]);
   end
endtask

// ----------------------------------------------------------
// Reference encoder
// ----------------------------------------------------------
// sr bit 1 is the previous input, bit 0 the one before
// Output bit 1 from generator 7, bit 0 from generator 5
function automatic logic [1:0] conv_encode(input logic u, input logic [1:0] sr);
   return {u ^ sr[1] ^ sr[0], u ^ sr[0]};
endfunction

// Encodes one source bit and queues it as expected output
task automatic encode_bit(input logic u, output logic [1:0] sym);
   sym    = conv_encode(u, enc_sr);
   enc_sr = {u, enc_sr[1]};
   exp_bits.push_back(u);
endtask

// ----------------------------------------------------------
// Queue helpers
// ----------------------------------------------------------
// Encoder back to state 0, nothing pending
task automatic clear_model();
   enc_sr  = 2'b00;
   sym_idx = 0;
   exp_bits.delete();
   exp_time.delete();
endtask

`endif

// File: sim/tb_viterbi_dec.sv
// ----------------------------------------------------------
// Viterbi decoder testbench
// Random source bits through a reference encoder, optional
// channel errors and idle gaps, decoded bits and pulse
// timing checked against the model queues
// ----------------------------------------------------------

`timescale 1ns/1ns

module tb_viterbi_dec
   import viterbi_pkg::*;
;

   localparam int TRACE_DEPTH   = 16;
   // Strobe edge to out_valid edge
   localparam int PIPE_LATENCY  = 3;
   localparam int N_RESET_SYMS  = 15;
   localparam int N_STREAM      = 200;
   localparam int N_PRE_RESET   = 40;
   localparam int N_POST_RESET  = 100;
   localparam int MAX_GAP       = 3;
   localparam int N_TOTAL       = N_RESET_SYMS + 3 * N_STREAM + N_PRE_RESET + N_POST_RESET;
   localparam int WATCHDOG_NS   = N_TOTAL * (MAX_GAP + 3) * 10 * 2;

   logic        clk;
   logic        rst_n;
   logic        in_valid;
   sym_t        in_sym;
   logic        out_valid;
   logic        out_bit;

   logic [15:0] lfsr_q;
   logic [1:0]  enc_sr;
   logic        exp_bits [$];
   int          exp_time [$];
   int          cyc;
   int          sym_idx;
   int          err_cnt;
   int          err_start;
   int          pulse_cnt;
   int          pass_cnt;
   int          fail_cnt;
   string       test_name;

   `include "tb_viterbi_model.svh"

   viterbi_dec UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_sym    (in_sym),
      .out_valid (out_valid),
      .out_bit   (out_bit)
   );

   // ----------------------------------------------------------
   // Clock, cycle count and watchdog
   // ----------------------------------------------------------
   always #5 clk = ~clk;

   // Count of rising edges seen so far as read at the falling edge
   always @(posedge clk)
   begin
      cyc <= cyc + 1;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog timeout, decoder output never completed");
      $display("Testbench failed");
      $finish;
   end

   // ----------------------------------------------------------
   // Output monitor sampled mid-cycle
   // ----------------------------------------------------------
   always @(negedge clk)
   begin
      logic exp_b;
      int   exp_t;
      if (out_valid)
      begin
         pulse_cnt++;
         if (exp_time.size() == 0 || exp_bits.size() == 0)
         begin
            $display("Test %s: out_valid pulse with no symbol due", test_name);
            err_cnt++;
         end
         else
         begin
            exp_t = exp_time.pop_front();
            exp_b = exp_bits.pop_front();
            if (exp_t != cyc)
            begin
               $display("** Error %s: pulse cycle expected %0d actual %0d",
                        test_name, exp_t, cyc);
               err_cnt++;
            end
            if (out_bit !== exp_b)
            begin
               $display("** Error %s: decoded bit expected %0b actual %0b",
                        test_name, exp_b, out_bit);
               err_cnt++;
            end
         end
      end
      else if (exp_time.size() > 0 && exp_time[0] <= cyc)
      begin
         $display("Test %s: out_valid pulse missing at cycle %0d", test_name, cyc);
         err_cnt++;
         exp_time.pop_front();
         if (exp_bits.size() > 0)
         begin
            exp_bits.pop_front();
         end
      end
   end

   // ----------------------------------------------------------
   // Stimulus tasks
   // ----------------------------------------------------------
   task automatic apply_reset();
      @(posedge clk);
      rst_n    <= 1'b0;
      in_valid <= 1'b0;
      // Pipeline is cleared once the first low edge is taken
      @(posedge clk);
      clear_model();
      @(posedge clk);
      rst_n <= 1'b1;
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      in_valid <= 1'b0;
   endtask

   // Encodes one random bit and optionally flips one symbol bit
   task automatic send_symbol(input logic flip_en, input logic flip_pos);
      int         b;
      logic [1:0] sym;
      take_bits(1, b);
      encode_bit(b[0], sym);
      if (flip_en)
      begin
         sym = sym ^ (flip_pos ? 2'b10 : 2'b01);
      end
      @(posedge clk);
      in_valid <= 1'b1;
      in_sym   <= sym_t'(sym);
      // Only symbols after a full window give a pulse
      if (sym_idx >= TRACE_DEPTH)
      begin
         exp_time.push_back(cyc + 1 + PIPE_LATENCY);
      end
      sym_idx++;
   endtask

   task automatic run_stream(input int n, input logic with_errors, input logic with_gaps);
      int gap;
      int pos;
      int next_flip;
      take_bits(3, next_flip);
      next_flip = next_flip + 20;
      for (int i = 0; i < n; i++)
      begin
         next_flip--;
         if (with_errors && next_flip == 0)
         begin
            take_bits(1, pos);
            send_symbol(1'b1, pos[0]);
            // Errors stay at least 20 symbols apart
            take_bits(3, next_flip);
            next_flip = next_flip + 20;
         end
         else
         begin
            send_symbol(1'b0, 1'b0);
         end
         if (with_gaps)
         begin
            take_bits(2, gap);
            repeat (gap) idle_cycle();
         end
      end
   endtask

   // ----------------------------------------------------------
   // Test bookkeeping
   // ----------------------------------------------------------
   task automatic start_test(input string name);
      test_name = name;
      err_start = err_cnt;
      pulse_cnt = 0;
   endtask

   // Waits for all due pulses and then checks the pulse count
   task automatic finish_test(input int exp_pulses);
      idle_cycle();
      while (exp_time.size() > 0)
      begin
         @(negedge clk);
      end
      repeat (PIPE_LATENCY + 1) @(negedge clk);
      if (pulse_cnt != exp_pulses)
      begin
         $display("** Error %s: pulse count expected %0d actual %0d",
                  test_name, exp_pulses, pulse_cnt);
         err_cnt++;
      end
      if (err_cnt == err_start)
      begin
         pass_cnt++;
         $display("Test %s: PASS, %0d pulses", test_name, pulse_cnt);
      end
      else
      begin
         fail_cnt++;
         $display("Test %s: FAIL, %0d errors", test_name, err_cnt - err_start);
      end
   endtask

   // ----------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------
   initial
   begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      in_valid  = 1'b0;
      in_sym    = '0;
      lfsr_q    = 16'd51956;
      enc_sr    = 2'b00;
      cyc       = 0;
      sym_idx   = 0;
      err_cnt   = 0;
      err_start = 0;
      pulse_cnt = 0;
      pass_cnt  = 0;
      fail_cnt  = 0;
      test_name = "init";

      // No pulse in reset or before the window fills
      start_test("reset_state");
      apply_reset();
      repeat (4) idle_cycle();
      run_stream(N_RESET_SYMS, 1'b0, 1'b0);
      finish_test(0);

      start_test("error_free");
      apply_reset();
      run_stream(N_STREAM, 1'b0, 1'b0);
      finish_test(N_STREAM - TRACE_DEPTH);

      // Stream continues from the previous test
      start_test("channel_errors");
      run_stream(N_STREAM, 1'b1, 1'b0);
      finish_test(N_STREAM);

      start_test("idle_gaps");
      run_stream(N_STREAM, 1'b0, 1'b1);
      finish_test(N_STREAM);

      // Reset lands while symbols are still in flight
      start_test("mid_reset");
      run_stream(N_PRE_RESET, 1'b0, 1'b0);
      apply_reset();
      pulse_cnt = 0;
      run_stream(N_POST_RESET, 1'b0, 1'b1);
      finish_test(N_POST_RESET - TRACE_DEPTH);

      $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
      begin
         $display("Testbench passed");
      end
      else
      begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: logic/viterbi_dec.sv
// ----------------------------------------------------------
// Hard-decision Viterbi decoder, rate 1/2, K=3, G=(7,5)
// Branch metric, add-compare-select and register-exchange
// survivor stages, three cycles from strobe to output
// ----------------------------------------------------------

`timescale 1ns/1ns

module viterbi_dec
   import viterbi_pkg::*;
#(
   // Path metric width
   parameter int PM_W        = 4,
   // Survivor length, also the decoding delay in symbols
   parameter int TRACE_DEPTH = 16
)
(
   input  logic clk,
   input  logic rst_n,
   input  logic in_valid,
   input  sym_t in_sym,
   output logic out_valid,
   output logic out_bit
);

   bm_t  bm_comb;
   bm_t  bm_q;
   acs_t acs_comb;
   acs_t acs_q;

   // ----------------------------------------------------------
   // Stage 1, branch metrics
   // ----------------------------------------------------------
   branch_metric u_branch_metric (
      .in_valid (in_valid),
      .in_sym   (in_sym),
      .bm       (bm_comb)
   );

   stage_reg #(
      .payload_t (bm_t)
   ) u_bm_reg (
      .clk   (clk),
      .rst_n (rst_n),
      .d     (bm_comb),
      .q     (bm_q)
   );

   // ----------------------------------------------------------
   // Stage 2, add-compare-select
   // ----------------------------------------------------------
   add_compare_select #(
      .PM_W (PM_W)
   ) u_acs (
      .clk   (clk),
      .rst_n (rst_n),
      .bm    (bm_q),
      .acs   (acs_comb)
   );

   stage_reg #(
      .payload_t (acs_t)
   ) u_acs_reg (
      .clk   (clk),
      .rst_n (rst_n),
      .d     (acs_comb),
      .q     (acs_q)
   );

   // ----------------------------------------------------------
   // Stage 3, survivor paths and decoded bit
   // ----------------------------------------------------------
   survivor_exchange #(
      .TRACE_DEPTH (TRACE_DEPTH)
   ) u_survivor (
      .clk       (clk),
      .rst_n     (rst_n),
      .acs       (acs_q),
      .out_valid (out_valid),
      .out_bit   (out_bit)
   );

endmodule

// File: logic/survivor_exchange.sv
// ----------------------------------------------------------
// Register-exchange survivor memory
// Keeps one decoded-bit path per state, copies paths along
// the selected branches, and emits the oldest bit of the
// best path once TRACE_DEPTH symbols have been seen
// ----------------------------------------------------------

`timescale 1ns/1ns

module survivor_exchange
   import viterbi_pkg::*;
#(
   parameter int TRACE_DEPTH = 16
)
(
   input  logic clk,
   input  logic rst_n,
   input  acs_t acs,
   output logic out_valid,
   output logic out_bit
);

   localparam int CNT_W = $clog2(TRACE_DEPTH + 1);

   // Bit TRACE_DEPTH-1 is the oldest, bit 0 the newest
   typedef logic [TRACE_DEPTH-1:0] path_t;

   path_t            path_q [NUM_STATES];
   path_t            path_d [NUM_STATES];
   logic [CNT_W-1:0] fill_q;
   logic             full;
   state_t           best_pred;

   // ----------------------------------------------------------
   // Path exchange
   // ----------------------------------------------------------
   always_comb
   begin
      for (int n = 0; n < NUM_STATES; n++)
      begin
         // Take the chosen predecessor's path, drop its oldest
         // bit, and append the input bit that enters state n
         path_d[n] = {path_q[pred_state(state_t'(n), acs.decision[n])][TRACE_DEPTH-2:0],
                      input_bit(state_t'(n))};
      end
   end

   // Predecessor on the best state's surviving branch
   assign best_pred = pred_state(acs.best_state, acs.decision[acs.best_state]);

   // Window holds real decisions only after TRACE_DEPTH steps
   assign full = (fill_q == CNT_W'(TRACE_DEPTH));

   // Paths advance one step per valid decision set
   always_ff @(posedge clk)
   begin
      if (acs.valid)
      begin
         path_q <= path_d;
      end
   end

   // ----------------------------------------------------------
   // Fill count and decoded output
   // ----------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         fill_q    <= '0;
         out_valid <= 1'b0;
         out_bit   <= 1'b0;
      end
      else
      begin
         // Saturates at TRACE_DEPTH
         if (acs.valid && !full)
         begin
            fill_q <= fill_q + 1'b1;
         end
         // Bit shifted out of the best path is the symbol
         // accepted TRACE_DEPTH steps ago
         if (acs.valid && full)
         begin
            out_valid <= 1'b1;
            out_bit   <= path_q[best_pred][TRACE_DEPTH-1];
         end
         else
         begin
            out_valid <= 1'b0;
         end
      end
   end

endmodule

// File: logic/add_compare_select.sv
// ----------------------------------------------------------
// Add-compare-select unit
// Holds the four path metrics, picks the surviving branch
// into each state, normalizes, and reports the best state
// Decisions are combinational and registered downstream
// ----------------------------------------------------------

`timescale 1ns/1ns

module add_compare_select
   import viterbi_pkg::*;
#(
   parameter int PM_W = 4
)
(
   input  logic clk,
   input  logic rst_n,
   input  bm_t  bm,
   output acs_t acs
);

   // Stored metric and one extra bit for the sum before normalizing
   typedef logic [PM_W-1:0] pm_t;
   typedef logic [PM_W:0]   sum_t;

   pm_t                   pm_q    [NUM_STATES];
   pm_t                   pm_d    [NUM_STATES];
   state_t                pred_lo [NUM_STATES];
   state_t                pred_hi [NUM_STATES];
   sum_t                  sum_lo  [NUM_STATES];
   sum_t                  sum_hi  [NUM_STATES];
   sum_t                  sel     [NUM_STATES];
   logic [NUM_STATES-1:0] dec;
   sum_t                  min_sum;
   state_t                best;

   // ----------------------------------------------------------
   // Add and compare-select
   // ----------------------------------------------------------
   always_comb
   begin
      for (int n = 0; n < NUM_STATES; n++)
      begin
         // Even and odd predecessors of state n
         pred_lo[n] = pred_state(state_t'(n), 1'b0);
         pred_hi[n] = pred_state(state_t'(n), 1'b1);
         // Metric plus cost of the branch label taken
         sum_lo[n]  = sum_t'(pm_q[pred_lo[n]])
                    + sum_t'(bm.metric[code_label(pred_lo[n], input_bit(state_t'(n)))]);
         sum_hi[n]  = sum_t'(pm_q[pred_hi[n]])
                    + sum_t'(bm.metric[code_label(pred_hi[n], input_bit(state_t'(n)))]);
         // Ties go to the lower predecessor
         if (sum_lo[n] <= sum_hi[n])
         begin
            sel[n] = sum_lo[n];
            dec[n] = 1'b0;
         end
         else
         begin
            sel[n] = sum_hi[n];
            dec[n] = 1'b1;
         end
      end
   end

   // ----------------------------------------------------------
   // Minimum search and normalization
   // ----------------------------------------------------------
   always_comb
   begin
      min_sum = sel[0];
      best    = '0;
      // Strict less-than keeps the lowest index on ties
      for (int n = 1; n < NUM_STATES; n++)
      begin
         if (sel[n] < min_sum)
         begin
            min_sum = sel[n];
            best    = state_t'(n);
         end
      end
      // Best state lands on 0 after the subtraction
      for (int n = 0; n < NUM_STATES; n++)
      begin
         pm_d[n] = pm_t'(sel[n] - min_sum);
      end
   end

   // Output for the acs stage register
   assign acs.valid      = bm.valid;
   assign acs.decision   = dec;
   assign acs.best_state = best;

   // ----------------------------------------------------------
   // Path metric registers
   // ----------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         // Encoder starts in state 0
         pm_q[0] <= '0;
         for (int n = 1; n < NUM_STATES; n++)
         begin
            pm_q[n] <= pm_t'(PM_RESET_BIAS);
         end
      end
      else if (bm.valid)
      begin
         pm_q <= pm_d;
      end
   end

endmodule

// File: logic/stage_reg.sv
// ----------------------------------------------------------
// Pipeline stage register
// Loads its payload every cycle, clears it on reset
// ----------------------------------------------------------

`timescale 1ns/1ns

module stage_reg
#(
   // Payload struct carried by this stage
   parameter type payload_t = logic
)
(
   input  logic     clk,
   input  logic     rst_n,
   input  payload_t d,
   output payload_t q
);

   // Valid flag lives inside the payload, so clearing it all
   // on reset also drops any pending strobe
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         q <= '0;
      end
      else
      begin
         // No enable, a stage with valid low just passes idle
         q <= d;
      end
   end

endmodule

// File: logic/branch_metric.sv
// ----------------------------------------------------------
// Branch metric unit
// Hamming distance of the received hard-decision symbol to
// each of the four code labels, purely combinational
// ----------------------------------------------------------

`timescale 1ns/1ns

module branch_metric
   import viterbi_pkg::*;
(
   input  logic in_valid,
   input  sym_t in_sym,
   output bm_t  bm
);

   // ----------------------------------------------------------
   // Distance helper
   // ----------------------------------------------------------
   // Counts differing bits between two 2-bit symbols
   function automatic bmet_t hamming(input sym_t a, input sym_t b);
      sym_t diff;
      diff = a ^ b;
      return bmet_t'(diff[1]) + bmet_t'(diff[0]);
   endfunction

   // ----------------------------------------------------------
   // Metric generation
   // ----------------------------------------------------------
   always_comb
   begin
      // Strobe passes straight through with the metrics
      bm.valid = in_valid;
      // One distance per label 00, 01, 10, 11
      for (int l = 0; l < NUM_LABELS; l++)
      begin
         bm.metric[l] = hamming(in_sym, sym_t'(l));
      end
   end

   // Label 0 and label 3 are complements, so their metrics
   // always sum to 2; same for labels 1 and 2
   // Nothing here is clocked, the stage_reg after this block
   // provides the pipeline cycle

endmodule

// File: logic/viterbi_pkg.sv
// ----------------------------------------------------------
// Viterbi decoder package
// Types and trellis helpers for the rate 1/2, K=3 code with
// generators 7 and 5 (octal), four-state trellis
// ----------------------------------------------------------

package viterbi_pkg;

   // ----------------------------------------------------------
   // Trellis constants
   // ----------------------------------------------------------
   localparam int SYM_W         = 2;
   localparam int STATE_W       = 2;
   localparam int NUM_STATES    = 4;
   // One branch label per 2-bit code symbol
   localparam int NUM_LABELS    = 4;
   // Hamming distance over 2 bits is 0..2
   localparam int BM_W          = 2;
   // Starting metric of states 1..3 so state 0 is favoured
   localparam int PM_RESET_BIAS = 4;

   // Bit 1 from generator 7, bit 0 from generator 5
   typedef logic [SYM_W-1:0]   sym_t;
   // Bit 1 newest input bit, bit 0 the one before
   typedef logic [STATE_W-1:0] state_t;
   typedef logic [BM_W-1:0]    bmet_t;

   // Branch metric stage output
   typedef struct packed {
      logic                         valid;
      bmet_t [NUM_LABELS-1:0]       metric;
   } bm_t;

   // ACS stage output, decision 0 = lower (even) predecessor
   typedef struct packed {
      logic                         valid;
      logic [NUM_STATES-1:0]        decision;
      state_t                       best_state;
   } acs_t;

   // ----------------------------------------------------------
   // Trellis helpers
   // ----------------------------------------------------------
   // Input bit that leads into state n
   function automatic logic input_bit(input state_t n);
      return n[1];
   endfunction

   // Predecessor of state n; upper picks the odd one
   function automatic state_t pred_state(input state_t n, input logic upper);
      return state_t'({n[0], upper});
   endfunction

   // Code symbol sent when input u leaves state p
   function automatic sym_t code_label(input state_t p, input logic u);
      return sym_t'({u ^ p[1] ^ p[0], u ^ p[0]});
   endfunction

endpackage
